// File: cpu_core.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/controller.sv
verilog/fetch_unit.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/cpu_core.sv
bench/clock_gen.sv
bench/cpu_tb.sv

// File: Makefile
TOP = cpu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -f cpu_core.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | awk '{ print } /SIMULATION PASSED/ { found = 1 } END { exit !found }'

clean:
	rm -rf obj_dir

// File: bench/cpu_tb.sv
module cpu_tb;
	import isa_pkg::*;

	// encodings written out from the instruction set tables
	localparam logic [5:0] opc_alu = 6'b100000;
	localparam logic [5:0] opc_addi = 6'b101000;
	localparam logic [5:0] opc_ori = 6'b101100;
	localparam logic [5:0] opc_xori = 6'b101011;
	localparam logic [5:0] opc_movi = 6'b100010;
	localparam logic [5:0] opc_lwi = 6'b000010;
	localparam logic [5:0] opc_swi = 6'b001010;
	localparam logic [5:0] opc_mem = 6'b011100;
	localparam logic [4:0] fn_add = 5'b00000;
	localparam logic [4:0] fn_sub = 5'b00001;
	localparam logic [4:0] fn_and = 5'b00010;
	localparam logic [4:0] fn_xor = 5'b00011;
	localparam logic [4:0] fn_or = 5'b00100;
	localparam logic [4:0] fn_slli = 5'b01000;
	localparam logic [4:0] fn_srli = 5'b01001;
	localparam logic [4:0] fn_rotri = 5'b01011;
	localparam logic [7:0] fn_lw = 8'b00000010;
	localparam logic [7:0] fn_sw = 8'b00001010;

	localparam logic [1:0] access_none = 2'd0;
	localparam logic [1:0] access_load = 2'd1;
	localparam logic [1:0] access_store = 2'd2;
	localparam int reset_cycles = 8;
	localparam int timeout_margin = 20;

	typedef struct packed {
		word_t instruction;
		logic [1:0] access;
		word_t address;
		word_t data;
	} program_row_t;

	logic clock;
	logic reset;
	logic im_enable;
	word_t im_address;
	word_t im_data;
	logic dm_enable;
	logic dm_read;
	logic dm_write;
	word_t dm_address;
	word_t dm_write_data;
	word_t dm_read_data;

	program_row_t program_rows[$];
	word_t model_regs [32];
	word_t model_mem [64];
	word_t data_mem [64];
	logic [31:0] lfsr_state;
	int error_count;
	int cycle_count;
	int cycle_limit;
	int store_slot;

	clock_gen clock_gen_i (
		.clock(clock),
		.reset(reset)
	);

	cpu_core dut_i (
		.clock(clock),
		.reset(reset),
		.im_enable(im_enable),
		.im_address(im_address),
		.im_data(im_data),
		.dm_enable(dm_enable),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_write_data(dm_write_data),
		.dm_read_data(dm_read_data)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < count; k++) begin
			lfsr_state = next_lfsr(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic word_t bit_word(input logic value);
		return {31'b0, value};
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("Error at time %0t: %s expected %h, actual %h",
				$time, name, expected, actual);
		end
	endtask

	task automatic check_idle_ports(input string phase_name);
		check_value({"im_enable in ", phase_name}, 32'd0, bit_word(im_enable));
		check_value({"dm_enable in ", phase_name}, 32'd0, bit_word(dm_enable));
	endtask

	task automatic queue_row(input word_t instruction, input logic [1:0] access,
		input word_t address, input word_t data);
		program_row_t row;
		row.instruction = instruction;
		row.access = access;
		row.address = address;
		row.data = data;
		program_rows.push_back(row);
	endtask

	// each instruction task updates the reference model and adds a row
	task automatic movi_instr(input reg_index_t rt, input logic [19:0] imm);
		model_regs[rt] = {{12{imm[19]}}, imm};
		queue_row({1'b0, opc_movi, rt, imm}, access_none, '0, '0);
	endtask

	task automatic alu_instr(input logic [4:0] fn, input reg_index_t rt, input reg_index_t ra,
		input reg_index_t rb);
		word_t a;
		word_t b;
		word_t value;
		a = model_regs[ra];
		b = model_regs[rb];
		case (fn)
			fn_add: value = a + b;
			fn_sub: value = a - b;
			fn_and: value = a & b;
			fn_or: value = a | b;
			fn_xor: value = a ^ b;
			fn_slli: value = a << rb;
			fn_srli: value = a >> rb;
			default: value = (a >> rb) | (a << (6'd32 - {1'b0, rb}));
		endcase
		model_regs[rt] = value;
		queue_row({1'b0, opc_alu, rt, ra, rb, 5'b0, fn}, access_none, '0, '0);
	endtask

	task automatic imm_instr(input logic [5:0] op, input reg_index_t rt, input reg_index_t ra,
		input logic [14:0] imm);
		word_t value;
		case (op)
			opc_addi: value = model_regs[ra] + {{17{imm[14]}}, imm};
			opc_ori: value = model_regs[ra] | {17'b0, imm};
			default: value = model_regs[ra] ^ {17'b0, imm};
		endcase
		model_regs[rt] = value;
		queue_row({1'b0, op, rt, ra, imm}, access_none, '0, '0);
	endtask

	task automatic swi_instr(input reg_index_t rt, input reg_index_t ra, input logic [14:0] imm);
		word_t address;
		address = model_regs[ra] + {{15{imm[14]}}, imm, 2'b00};
		model_mem[address[7:2]] = model_regs[rt];
		queue_row({1'b0, opc_swi, rt, ra, imm}, access_store, address, model_regs[rt]);
	endtask

	task automatic lwi_instr(input reg_index_t rt, input reg_index_t ra, input logic [14:0] imm);
		word_t address;
		address = model_regs[ra] + {{15{imm[14]}}, imm, 2'b00};
		model_regs[rt] = model_mem[address[7:2]];
		queue_row({1'b0, opc_lwi, rt, ra, imm}, access_load, address, model_regs[rt]);
	endtask

	task automatic lw_instr(input reg_index_t rt, input reg_index_t ra, input reg_index_t rb,
		input logic [1:0] sv);
		word_t address;
		address = model_regs[ra] + (model_regs[rb] << sv);
		model_regs[rt] = model_mem[address[7:2]];
		queue_row({1'b0, opc_mem, rt, ra, rb, sv, fn_lw}, access_load, address, model_regs[rt]);
	endtask

	task automatic sw_instr(input reg_index_t rt, input reg_index_t ra, input reg_index_t rb,
		input logic [1:0] sv);
		word_t address;
		address = model_regs[ra] + (model_regs[rb] << sv);
		model_mem[address[7:2]] = model_regs[rt];
		queue_row({1'b0, opc_mem, rt, ra, rb, sv, fn_sw}, access_store, address, model_regs[rt]);
	endtask

	// r30 is the base of the result area
	task automatic store_result(input reg_index_t rt);
		swi_instr(rt, 5'd30, 15'(store_slot));
		store_slot++;
	endtask

	task automatic build_program();
		logic [3:0] offset;
		logic [2:0] word_index;
		word_t rb_value;
		movi_instr(5'd30, 20'd64);
		movi_instr(5'd1, 20'(random_bits(20)));
		movi_instr(5'd2, 20'(random_bits(20)));
		alu_instr(fn_add, 5'd3, 5'd1, 5'd2);
		store_result(5'd3);
		alu_instr(fn_sub, 5'd3, 5'd1, 5'd2);
		store_result(5'd3);
		alu_instr(fn_and, 5'd3, 5'd1, 5'd2);
		store_result(5'd3);
		alu_instr(fn_or, 5'd3, 5'd1, 5'd2);
		store_result(5'd3);
		alu_instr(fn_xor, 5'd3, 5'd1, 5'd2);
		store_result(5'd3);
		repeat (2) begin
			alu_instr(fn_slli, 5'd4, 5'd1, 5'(random_bits(5)));
			store_result(5'd4);
			alu_instr(fn_srli, 5'd4, 5'd1, 5'(random_bits(5)));
			store_result(5'd4);
			alu_instr(fn_rotri, 5'd4, 5'd2, 5'(random_bits(5)));
			store_result(5'd4);
		end
		// negative addi, then or/xor with bit 14 set
		repeat (2) begin
			imm_instr(opc_addi, 5'd5, 5'd2, {1'b1, 14'(random_bits(14))});
			store_result(5'd5);
		end
		imm_instr(opc_ori, 5'd6, 5'd1, {1'b1, 14'(random_bits(14))});
		store_result(5'd6);
		imm_instr(opc_xori, 5'd7, 5'd2, {1'b1, 14'(random_bits(14))});
		store_result(5'd7);
		// word offsets from -8 to 7 around byte 128
		movi_instr(5'd29, 20'd128);
		repeat (3) begin
			offset = 4'(random_bits(4));
			lwi_instr(5'd8, 5'd29, {{11{offset[3]}}, offset});
			store_result(5'd8);
		end
		for (int s = 0; s < 4; s++) begin
			word_index = 3'(random_bits(3));
			if (s == 3) begin
				rb_value = {29'b0, word_index};
			end else begin
				rb_value = {29'b0, word_index} << (2 - s);
			end
			movi_instr(5'd12, {14'b0, 4'(random_bits(4)), 2'b00});
			movi_instr(5'd13, rb_value[19:0]);
			lw_instr(5'd14, 5'd12, 5'd13, 2'(s));
			sw_instr(5'd14, 5'd30, 5'd13, 2'(s));
		end
	endtask

	initial begin
		int last_fetch;
		program_row_t row;
		logic read_pending;
		word_t read_word;
		im_data = '0;
		dm_read_data = '0;
		error_count = 0;
		store_slot = 0;
		last_fetch = 0;
		lfsr_state = 32'hb07e287d;
		for (int i = 0; i < 64; i++) begin
			data_mem[i] = random_bits(32);
			model_mem[i] = data_mem[i];
		end
		build_program();
		cycle_limit = 4 * program_rows.size() + reset_cycles + timeout_margin;

		@(posedge clock);
		@(negedge clock);
		while (reset) begin
			check_idle_ports("reset");
			@(negedge clock);
		end

		foreach (program_rows[i]) begin
			row = program_rows[i];
			while (im_enable !== 1'b1) begin
				check_value("dm_enable before fetch", 32'd0, bit_word(dm_enable));
				@(negedge clock);
			end
			check_value("im_address", 32'(i * 4), im_address);
			if (i > 0) begin
				check_value("fetch interval", 32'd4, 32'(cycle_count - last_fetch));
			end
			last_fetch = cycle_count;
			@(posedge clock);
			#1;
			im_data = row.instruction;

			@(negedge clock);
			check_idle_ports("fetch_latch");

			@(negedge clock);
			check_value("im_enable in execute", 32'd0, bit_word(im_enable));
			check_value("dm_enable", bit_word(row.access != access_none), bit_word(dm_enable));
			check_value("dm_read", bit_word(row.access == access_load), bit_word(dm_read));
			check_value("dm_write", bit_word(row.access == access_store), bit_word(dm_write));
			if (row.access != access_none) begin
				check_value("dm_address", row.address, dm_address);
			end
			if (row.access == access_store) begin
				check_value("dm_write_data", row.data, dm_write_data);
			end
			// data memory answers from what the DUT drives
			read_pending = dm_enable & dm_read;
			read_word = data_mem[dm_address[7:2]];
			if (dm_enable && dm_write) begin
				data_mem[dm_address[7:2]] = dm_write_data;
			end
			@(posedge clock);
			#1;
			if (read_pending) begin
				dm_read_data = read_word;
			end

			@(negedge clock);
			check_idle_ports("writeback");
			@(negedge clock);
		end

		$display("Run finished: %0d errors in %0d instructions", error_count, program_rows.size());
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: program not finished after %0d cycles", cycle_limit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: bench/clock_gen.sv
module clock_gen (
	output logic clock,
	output logic reset
);
	localparam int half_period = 5;
	localparam int reset_cycles = 8;

	initial begin
		clock = 1'b0;
		forever begin
			#half_period clock = ~clock;
		end
	end

	// release just after a rising edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		#1;
		reset = 1'b0;
	end

endmodule

// File: verilog/cpu_core.sv
module cpu_core (
	input logic clock,
	input logic reset,
	output logic im_enable,
	output isa_pkg::word_t im_address,
	input isa_pkg::word_t im_data,
	output logic dm_enable,
	output logic dm_read,
	output logic dm_write,
	output isa_pkg::word_t dm_address,
	output isa_pkg::word_t dm_write_data,
	input isa_pkg::word_t dm_read_data
);
	import isa_pkg::*;
	import core_pkg::*;

	word_t instruction;
	word_t pc;
	control_word_t control;
	logic latch_instruction;
	logic execute_strobe;
	logic writeback_strobe;
	logic reg_write_enable;
	word_t read_a;
	word_t read_b;
	word_t write_data;

	controller controller_i (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.control(control),
		.latch_instruction(latch_instruction),
		.execute_strobe(execute_strobe),
		.writeback_strobe(writeback_strobe),
		.im_enable(im_enable),
		.dm_enable(dm_enable)
	);

	fetch_unit fetch_unit_i (
		.clock(clock),
		.reset(reset),
		.latch_instruction(latch_instruction),
		.im_data(im_data),
		.pc(pc),
		.instruction(instruction)
	);

	// third read port carries the store data from rt
	register_file register_file_i (
		.clock(clock),
		.read_a_index(get_ra(instruction)),
		.read_b_index(get_rb(instruction)),
		.read_c_index(get_rt(instruction)),
		.read_a(read_a),
		.read_b(read_b),
		.read_c(dm_write_data),
		.write_enable(reg_write_enable),
		.write_index(get_rt(instruction)),
		.write_data(write_data)
	);

	execute_unit execute_unit_i (
		.clock(clock),
		.reset(reset),
		.execute_strobe(execute_strobe),
		.control(control),
		.instruction(instruction),
		.read_a(read_a),
		.read_b(read_b),
		.dm_read_data(dm_read_data),
		.dm_address(dm_address),
		.write_data(write_data)
	);

	assign im_address = pc;
	assign reg_write_enable = writeback_strobe & control.reg_write;
	assign dm_read = execute_strobe & control.dm_read;
	assign dm_write = execute_strobe & control.dm_write;

endmodule

// File: verilog/execute_unit.sv
module execute_unit (
	input logic clock,
	input logic reset,
	input logic execute_strobe,
	input core_pkg::control_word_t control,
	input isa_pkg::word_t instruction,
	input isa_pkg::word_t read_a,
	input isa_pkg::word_t read_b,
	input isa_pkg::word_t dm_read_data,
	output isa_pkg::word_t dm_address,
	output isa_pkg::word_t write_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [14:0] imm15;
	logic [19:0] imm20;
	logic [4:0] shift_amount;
	word_t shift_imm;
	word_t signed_imm;
	word_t unsigned_imm;
	word_t offset_imm;
	word_t move_value;
	word_t operand_b;
	word_t alu_out;
	word_t result;
	word_t result_q;

	assign imm15 = get_imm15(instruction);
	assign imm20 = get_imm20(instruction);
	assign shift_imm = {27'b0, get_imm5(instruction)};
	assign signed_imm = {{17{imm15[14]}}, imm15};
	assign unsigned_imm = {17'b0, imm15};
	assign offset_imm = {signed_imm[29:0], 2'b00};
	assign move_value = {{12{imm20[19]}}, imm20};

	always_comb begin
		case (control.operand_select)
			from_register: operand_b = read_b;
			from_shift_imm: operand_b = shift_imm;
			from_offset_imm: operand_b = offset_imm;
			default: operand_b = read_b << get_sv(instruction);
		endcase
	end

	assign shift_amount = operand_b[4:0];

	always_comb begin
		case (control.alu_op)
			alu_add: alu_out = read_a + operand_b;
			alu_sub: alu_out = read_a - operand_b;
			alu_and: alu_out = read_a & operand_b;
			alu_or: alu_out = read_a | operand_b;
			alu_xor: alu_out = read_a ^ operand_b;
			alu_sll: alu_out = read_a << shift_amount;
			alu_srl: alu_out = read_a >> shift_amount;
			default: alu_out = word_t'({read_a, read_a} >> shift_amount);
		endcase
	end

	always_comb begin
		case (control.result_select)
			alu_result: result = alu_out;
			add_signed_imm: result = read_a + signed_imm;
			logic_unsigned_imm: begin
				if (control.alu_op == alu_xor) begin
					result = read_a ^ unsigned_imm;
				end else begin
					result = read_a | unsigned_imm;
				end
			end
			default: result = move_value;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			result_q <= '0;
		end else if (execute_strobe) begin
			result_q <= result;
		end
	end

	// loads and stores decode to alu_add over the offset operand
	assign dm_address = alu_out;
	assign write_data = (control.writeback_select == from_memory) ? dm_read_data : result_q;

endmodule

// File: verilog/register_file.sv
module register_file (
	input logic clock,
	input isa_pkg::reg_index_t read_a_index,
	input isa_pkg::reg_index_t read_b_index,
	input isa_pkg::reg_index_t read_c_index,
	output isa_pkg::word_t read_a,
	output isa_pkg::word_t read_b,
	output isa_pkg::word_t read_c,
	input logic write_enable,
	input isa_pkg::reg_index_t write_index,
	input isa_pkg::word_t write_data
);
	import isa_pkg::*;

	word_t registers [32];

	always_ff @(posedge clock) begin
		if (write_enable) begin
			registers[write_index] <= write_data;
		end
	end

	// r0 is not hardwired
	assign read_a = registers[read_a_index];
	assign read_b = registers[read_b_index];
	assign read_c = registers[read_c_index];

endmodule

// File: verilog/fetch_unit.sv
module fetch_unit (
	input logic clock,
	input logic reset,
	input logic latch_instruction,
	input isa_pkg::word_t im_data,
	output isa_pkg::word_t pc,
	output isa_pkg::word_t instruction
);

	// im_data is valid in the latch phase, one cycle after im_enable
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			instruction <= '0;
		end else if (latch_instruction) begin
			pc <= pc + 32'd4;
			instruction <= im_data;
		end
	end

endmodule

// File: verilog/controller.sv
module controller (
	input logic clock,
	input logic reset,
	input isa_pkg::word_t instruction,
	output core_pkg::control_word_t control,
	output logic latch_instruction,
	output logic execute_strobe,
	output logic writeback_strobe,
	output logic im_enable,
	output logic dm_enable
);
	import isa_pkg::*;
	import core_pkg::*;

	phase_t phase;
	phase_t next_phase;
	logic running;
	logic ir_valid;
	control_word_t decoded;

	always_comb begin
		case (phase)
			fetch_request: next_phase = fetch_latch;
			fetch_latch: next_phase = execute;
			execute: next_phase = writeback;
			default: next_phase = fetch_request;
		endcase
	end

	// first cycle out of reset is spent idle in fetch_request
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= fetch_request;
			running <= 1'b0;
		end else begin
			running <= 1'b1;
			if (running) begin
				phase <= next_phase;
			end
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ir_valid <= 1'b0;
		end else if (latch_instruction) begin
			ir_valid <= 1'b1;
		end
	end

	always_comb begin
		decoded = control_nop;
		case (get_opcode(instruction))
			op_alu_base: begin
				decoded.reg_write = 1'b1;
				case (get_base_subop(instruction))
					subop_add: decoded.alu_op = alu_add;
					subop_sub: decoded.alu_op = alu_sub;
					subop_and: decoded.alu_op = alu_and;
					subop_or: decoded.alu_op = alu_or;
					subop_xor: decoded.alu_op = alu_xor;
					subop_slli: begin
						decoded.operand_select = from_shift_imm;
						decoded.alu_op = alu_sll;
					end
					subop_srli: begin
						decoded.operand_select = from_shift_imm;
						decoded.alu_op = alu_srl;
					end
					subop_rotri: begin
						decoded.operand_select = from_shift_imm;
						decoded.alu_op = alu_ror;
					end
					default: decoded = control_nop;
				endcase
			end
			op_addi: begin
				decoded.result_select = add_signed_imm;
				decoded.reg_write = 1'b1;
			end
			op_ori: begin
				decoded.result_select = logic_unsigned_imm;
				decoded.alu_op = alu_or;
				decoded.reg_write = 1'b1;
			end
			op_xori: begin
				decoded.result_select = logic_unsigned_imm;
				decoded.alu_op = alu_xor;
				decoded.reg_write = 1'b1;
			end
			op_movi: begin
				decoded.result_select = move_imm;
				decoded.reg_write = 1'b1;
			end
			op_lwi: begin
				decoded.operand_select = from_offset_imm;
				decoded.writeback_select = from_memory;
				decoded.reg_write = 1'b1;
				decoded.dm_read = 1'b1;
			end
			op_swi: begin
				decoded.operand_select = from_offset_imm;
				decoded.dm_write = 1'b1;
			end
			op_mem: begin
				case (get_mem_subop(instruction))
					subop_lw: begin
						decoded.operand_select = from_scaled_register;
						decoded.writeback_select = from_memory;
						decoded.reg_write = 1'b1;
						decoded.dm_read = 1'b1;
					end
					subop_sw: begin
						decoded.operand_select = from_scaled_register;
						decoded.dm_write = 1'b1;
					end
					default: decoded = control_nop;
				endcase
			end
			default: decoded = control_nop;
		endcase
	end

	// the reset value of the instruction register must never write
	always_comb begin
		control = decoded;
		control.reg_write = decoded.reg_write & ir_valid;
	end

	assign im_enable = running & (phase == fetch_request);
	assign latch_instruction = (phase == fetch_latch);
	assign execute_strobe = (phase == execute);
	assign writeback_strobe = (phase == writeback);
	assign dm_enable = execute_strobe & (control.dm_read | control.dm_write);

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

	typedef enum logic [1:0] {
		fetch_request,
		fetch_latch,
		execute,
		writeback
	} phase_t;

	// second alu operand
	typedef enum logic [1:0] {
		from_register,
		from_shift_imm,
		from_offset_imm,
		from_scaled_register
	} operand_select_t;

	typedef enum logic [1:0] {
		alu_result,
		add_signed_imm,
		logic_unsigned_imm,
		move_imm
	} result_select_t;

	typedef enum logic {
		from_execute,
		from_memory
	} writeback_select_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_ror
	} alu_op_t;

	typedef struct packed {
		operand_select_t operand_select;
		result_select_t result_select;
		writeback_select_t writeback_select;
		alu_op_t alu_op;
		logic reg_write;
		logic dm_read;
		logic dm_write;
	} control_word_t;

	// no register write, no memory access
	localparam control_word_t control_nop = '{
		operand_select: from_register,
		result_select: alu_result,
		writeback_select: from_execute,
		alu_op: alu_add,
		reg_write: 1'b0,
		dm_read: 1'b0,
		dm_write: 1'b0
	};

endpackage

// File: verilog/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_index_t;
	typedef logic [5:0] opcode_t;
	typedef logic [4:0] base_subop_t;
	typedef logic [7:0] mem_subop_t;
	typedef logic [1:0] shift_scale_t;

	// primary opcodes, bits 30 to 25
	localparam opcode_t op_alu_base = 6'b100000;
	localparam opcode_t op_addi = 6'b101000;
	localparam opcode_t op_ori = 6'b101100;
	localparam opcode_t op_xori = 6'b101011;
	localparam opcode_t op_movi = 6'b100010;
	localparam opcode_t op_lwi = 6'b000010;
	localparam opcode_t op_swi = 6'b001010;
	localparam opcode_t op_mem = 6'b011100;

	// sub-opcodes under op_alu_base
	localparam base_subop_t subop_add = 5'b00000;
	localparam base_subop_t subop_sub = 5'b00001;
	localparam base_subop_t subop_and = 5'b00010;
	localparam base_subop_t subop_xor = 5'b00011;
	localparam base_subop_t subop_or = 5'b00100;
	localparam base_subop_t subop_slli = 5'b01000;
	localparam base_subop_t subop_srli = 5'b01001;
	localparam base_subop_t subop_rotri = 5'b01011;

	// sub-opcodes under op_mem
	localparam mem_subop_t subop_lw = 8'b00000010;
	localparam mem_subop_t subop_sw = 8'b00001010;

	function automatic opcode_t get_opcode(word_t instruction);
		return instruction[30:25];
	endfunction

	function automatic base_subop_t get_base_subop(word_t instruction);
		return instruction[4:0];
	endfunction

	function automatic mem_subop_t get_mem_subop(word_t instruction);
		return instruction[7:0];
	endfunction

	function automatic reg_index_t get_rt(word_t instruction);
		return instruction[24:20];
	endfunction

	function automatic reg_index_t get_ra(word_t instruction);
		return instruction[19:15];
	endfunction

	function automatic reg_index_t get_rb(word_t instruction);
		return instruction[14:10];
	endfunction

	function automatic shift_scale_t get_sv(word_t instruction);
		return instruction[9:8];
	endfunction

	// imm5 shares its bits with rb
	function automatic logic [4:0] get_imm5(word_t instruction);
		return instruction[14:10];
	endfunction

	function automatic logic [14:0] get_imm15(word_t instruction);
		return instruction[14:0];
	endfunction

	function automatic logic [19:0] get_imm20(word_t instruction);
		return instruction[19:0];
	endfunction

endpackage
